// File: hw/ex_pkg.sv
package ex_pkg;

    localparam int xlen         = 32;
    localparam int rob_tag_bits = 5;

    // ALU operations, RV32I plus the M-extension multiplies
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_slt    = 4'd2,
        alu_sltu   = 4'd3,
        alu_and    = 4'd4,
        alu_or     = 4'd5,
        alu_xor    = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_mul    = 4'd10,
        alu_mulh   = 4'd11,
        alu_mulhsu = 4'd12,
        alu_mulhu  = 4'd13
    } alu_func_e;

    typedef enum logic [1:0] {
        opa_is_rs1  = 2'd0,
        opa_is_npc  = 2'd1,
        opa_is_pc   = 2'd2,
        opa_is_zero = 2'd3
    } opa_select_e;

    typedef enum logic [2:0] {
        opb_is_rs2   = 3'd0,
        opb_is_i_imm = 3'd1,
        opb_is_s_imm = 3'd2,
        opb_is_b_imm = 3'd3,
        opb_is_u_imm = 3'd4,
        opb_is_j_imm = 3'd5
    } opb_select_e;

    // Decoded instruction as it leaves ID
    typedef struct packed {
        logic [31:0]     inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;          // pc + 4
        opa_select_e     opa_select;
        opb_select_e     opb_select;
        alu_func_e       alu_func;
        logic            rd_mem;       // Load
        logic            wr_mem;       // Store
        logic            cond_branch;
        logic            uncond_branch; // jal, jalr
    } id_ex_packet_t;

    // Entry issued by the reservation station, operands already resolved
    typedef struct packed {
        logic                    ready;
        id_ex_packet_t           instr;
        logic [xlen-1:0]         rs1_value;
        logic [xlen-1:0]         rs2_value;
        logic [rob_tag_bits-1:0] rd_tag;
    } instr_ready_entry_t;

    // Result broadcast on the CDB
    typedef struct packed {
        logic                    valid;
        logic [xlen-1:0]         value;
        logic [rob_tag_bits-1:0] rob_tag;
        logic [xlen-1:0]         npc;
        logic [31:0]             inst;
    } ex_wr_packet_t;

    // Request into the load buffer
    typedef struct packed {
        logic                    valid;
        logic [xlen-1:0]         address;
        logic [rob_tag_bits-1:0] rd_tag;
        logic [2:0]              mem_size;  // funct3 of the load
        logic [xlen-1:0]         npc;
        logic [31:0]             inst;
    } lb_packet_t;

    typedef struct packed {
        logic            take_branch;
        logic [xlen-1:0] target_pc;
    } branch_result_t;

    // Immediate extraction, all sign extended from bit 31
    function automatic logic [xlen-1:0] i_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [xlen-1:0] s_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    // Branch offset, bit 0 always zero
    function automatic logic [xlen-1:0] b_imm(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [xlen-1:0] u_imm(input logic [31:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    // Jump offset, 21 bits before extension
    function automatic logic [xlen-1:0] j_imm(input logic [31:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic logic [2:0] funct3(input logic [31:0] inst);
        return inst[14:12];
    endfunction

endpackage

// File: hw/alu.sv
module alu (
    input  logic [ex_pkg::xlen-1:0] opa,
    input  logic [ex_pkg::xlen-1:0] opb,
    input  ex_pkg::alu_func_e       func,
    output logic [ex_pkg::xlen-1:0] result
);
    import ex_pkg::*;

    logic signed [2*xlen-1:0] prod_ss;   // signed x signed
    logic signed [2*xlen-1:0] prod_su;   // signed x unsigned
    logic        [2*xlen-1:0] prod_uu;
    logic                     lt_signed;
    logic                     lt_unsigned;

    // Operands widened to 64 bits so the products are exact
    assign prod_ss = $signed({{xlen{opa[xlen-1]}}, opa}) * $signed({{xlen{opb[xlen-1]}}, opb});
    assign prod_su = $signed({{xlen{opa[xlen-1]}}, opa}) * $signed({{xlen{1'b0}}, opb});
    assign prod_uu = {{xlen{1'b0}}, opa} * {{xlen{1'b0}}, opb};

    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            alu_add:    result = opa + opb;
            alu_sub:    result = opa - opb;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_and:    result = opa & opb;
            alu_or:     result = opa | opb;
            alu_xor:    result = opa ^ opb;
            alu_sll:    result = opa << opb[4:0];
            alu_srl:    result = opa >> opb[4:0];
            alu_sra:    result = $signed(opa) >>> opb[4:0];   // Sign fill
            alu_mul:    result = prod_ss[xlen-1:0];
            alu_mulh:   result = prod_ss[2*xlen-1:xlen];
            alu_mulhsu: result = prod_su[2*xlen-1:xlen];
            alu_mulhu:  result = prod_uu[2*xlen-1:xlen];
            default:    result = 32'hfacebeec;   // Unused code marker
        endcase
    end

endmodule

// File: hw/brcond.sv
module brcond (
    input  logic [ex_pkg::xlen-1:0] rs1,
    input  logic [ex_pkg::xlen-1:0] rs2,
    input  logic [2:0]              func,   // funct3 of the branch
    output logic                    cond
);
    import ex_pkg::*;

    logic signed [xlen-1:0] rs1_s;
    logic signed [xlen-1:0] rs2_s;

    assign rs1_s = rs1;
    assign rs2_s = rs2;

    always_comb begin
        cond = 1'b0;   // 010 and 011 are not branches
        case (func)
            3'b000: cond = rs1 == rs2;       // beq
            3'b001: cond = rs1 != rs2;       // bne
            3'b100: cond = rs1_s < rs2_s;    // blt
            3'b101: cond = rs1_s >= rs2_s;   // bge
            3'b110: cond = rs1 < rs2;        // bltu
            3'b111: cond = rs1 >= rs2;       // bgeu
            default: cond = 1'b0;
        endcase
    end

endmodule

// File: hw/operand_select.sv
module operand_select (
    input  ex_pkg::instr_ready_entry_t entry,
    output logic [ex_pkg::xlen-1:0]    opa,
    output logic [ex_pkg::xlen-1:0]    opb,
    output ex_pkg::alu_func_e          func
);
    import ex_pkg::*;

    id_ex_packet_t instr;

    assign instr = entry.instr;
    assign func  = instr.alu_func;

    // Operand A
    always_comb begin
        case (instr.opa_select)
            opa_is_rs1:  opa = entry.rs1_value;
            opa_is_npc:  opa = instr.npc;
            opa_is_pc:   opa = instr.pc;
            opa_is_zero: opa = '0;
            default:     opa = 32'hdeadfbac;   // Illegal select
        endcase
    end

    // Operand B, register or one of the immediate formats
    always_comb begin
        case (instr.opb_select)
            opb_is_rs2:   opb = entry.rs2_value;
            opb_is_i_imm: opb = i_imm(instr.inst);   // ALU imm, loads, jalr
            opb_is_s_imm: opb = s_imm(instr.inst);   // Stores
            opb_is_b_imm: opb = b_imm(instr.inst);
            opb_is_u_imm: opb = u_imm(instr.inst);   // lui, auipc
            opb_is_j_imm: opb = j_imm(instr.inst);
            default:      opb = 32'hfacefeed;        // Illegal select
        endcase
    end

endmodule

// File: hw/alu_execution_unit.sv
module alu_execution_unit (
    input  ex_pkg::instr_ready_entry_t entry,
    output ex_pkg::ex_wr_packet_t      cdb,
    output ex_pkg::branch_result_t     branch
);
    import ex_pkg::*;

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    alu_func_e       func;
    logic [xlen-1:0] result;
    logic            cond;
    logic            is_branch;
    logic            taken;

    operand_select u_operand_select (
        .entry (entry),
        .opa   (opa),
        .opb   (opb),
        .func  (func)
    );

    alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (result)
    );

    brcond u_brcond (
        .rs1  (entry.rs1_value),
        .rs2  (entry.rs2_value),
        .func (funct3(entry.instr.inst)),
        .cond (cond)
    );

    assign is_branch = entry.instr.cond_branch | entry.instr.uncond_branch;
    assign taken     = entry.instr.uncond_branch | (entry.instr.cond_branch & cond);

    always_comb begin
        cdb    = '0;
        branch = '0;
        if (entry.ready) begin
            cdb.valid   = 1'b1;
            cdb.rob_tag = entry.rd_tag;
            cdb.npc     = entry.instr.npc;
            cdb.inst    = entry.instr.inst;
            if (taken) begin
                branch.take_branch = 1'b1;
                branch.target_pc   = result;
                cdb.value          = entry.instr.npc;   // Link value
            end else if (!is_branch) begin
                cdb.value = result;
            end
            // Not-taken branch leaves value at zero
        end
    end

endmodule

// File: hw/address_calculation_unit.sv
module address_calculation_unit (
    input  ex_pkg::instr_ready_entry_t entry,
    output ex_pkg::ex_wr_packet_t      store_cdb,
    output ex_pkg::lb_packet_t         lb_request
);
    import ex_pkg::*;

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    alu_func_e       func;
    logic [xlen-1:0] address;

    operand_select u_operand_select (
        .entry (entry),
        .opa   (opa),
        .opb   (opb),
        .func  (func)
    );

    // Normally rs1 plus the I or S immediate
    alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (address)
    );

    always_comb begin
        store_cdb.valid   = entry.ready & ~entry.instr.rd_mem;   // Anything else is a store
        store_cdb.value   = address;
        store_cdb.rob_tag = entry.rd_tag;
        store_cdb.npc     = entry.instr.npc;
        store_cdb.inst    = entry.instr.inst;

        lb_request.valid    = entry.ready & entry.instr.rd_mem;
        lb_request.address  = address;
        lb_request.rd_tag   = entry.rd_tag;
        lb_request.mem_size = funct3(entry.instr.inst);   // Byte, half, word and unsigned
        lb_request.npc      = entry.instr.npc;
        lb_request.inst     = entry.instr.inst;
    end

endmodule

// File: hw/ex_stage_regs.sv
module ex_stage_regs (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   squash,
    input  ex_pkg::ex_wr_packet_t  alu_cdb_in,
    input  ex_pkg::ex_wr_packet_t  store_cdb_in,
    input  ex_pkg::lb_packet_t     lb_in,
    input  ex_pkg::branch_result_t branch_in,
    output ex_pkg::ex_wr_packet_t  alu_cdb,
    output ex_pkg::ex_wr_packet_t  store_cdb,
    output ex_pkg::lb_packet_t     lb_request,
    output ex_pkg::branch_result_t branch
);
    import ex_pkg::*;

    logic           alu_valid_q;
    logic           store_valid_q;
    logic           lb_valid_q;
    branch_result_t branch_q;
    ex_wr_packet_t  alu_data_q;
    ex_wr_packet_t  store_data_q;
    lb_packet_t     lb_data_q;

    // Control state, cleared on reset and on a ROB squash
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alu_valid_q   <= 1'b0;
            store_valid_q <= 1'b0;
            lb_valid_q    <= 1'b0;
            branch_q      <= '0;
        end else if (squash) begin
            alu_valid_q   <= 1'b0;   // Drops entries issued this cycle
            store_valid_q <= 1'b0;
            lb_valid_q    <= 1'b0;
            branch_q      <= '0;
        end else begin
            alu_valid_q   <= alu_cdb_in.valid;
            store_valid_q <= store_cdb_in.valid;
            lb_valid_q    <= lb_in.valid;
            branch_q      <= branch_in;
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        alu_data_q   <= alu_cdb_in;
        store_data_q <= store_cdb_in;
        lb_data_q    <= lb_in;
    end

    always_comb begin
        alu_cdb         = alu_data_q;
        alu_cdb.valid   = alu_valid_q;
        store_cdb       = store_data_q;
        store_cdb.valid = store_valid_q;
        lb_request       = lb_data_q;
        lb_request.valid = lb_valid_q;
        branch           = branch_q;
    end

endmodule

// File: hw/execute_stage.sv
module execute_stage (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       squash,      // ROB misprediction flush
    input  ex_pkg::instr_ready_entry_t alu_entry,
    input  ex_pkg::instr_ready_entry_t mem_entry,
    output ex_pkg::ex_wr_packet_t      alu_cdb,
    output ex_pkg::ex_wr_packet_t      store_cdb,
    output ex_pkg::lb_packet_t         lb_request,
    output ex_pkg::branch_result_t     branch
);
    import ex_pkg::*;

    ex_wr_packet_t  alu_cdb_c;
    ex_wr_packet_t  store_cdb_c;
    lb_packet_t     lb_c;
    branch_result_t branch_c;

    // Integer and branch port
    alu_execution_unit u_alu_unit (
        .entry  (alu_entry),
        .cdb    (alu_cdb_c),
        .branch (branch_c)
    );

    // Load and store port
    address_calculation_unit u_addr_unit (
        .entry      (mem_entry),
        .store_cdb  (store_cdb_c),
        .lb_request (lb_c)
    );

    ex_stage_regs u_regs (
        .clock        (clock),
        .arst_n       (arst_n),
        .squash       (squash),
        .alu_cdb_in   (alu_cdb_c),
        .store_cdb_in (store_cdb_c),
        .lb_in        (lb_c),
        .branch_in    (branch_c),
        .alu_cdb      (alu_cdb),
        .store_cdb    (store_cdb),
        .lb_request   (lb_request),
        .branch       (branch)
    );

endmodule

// File: verification/execute_stage_props.sv
module execute_stage_props (
    input logic                   clock,
    input logic                   arst_n,
    input logic                   squash,
    input ex_pkg::ex_wr_packet_t  alu_cdb,
    input ex_pkg::ex_wr_packet_t  store_cdb,
    input ex_pkg::lb_packet_t     lb_request,
    input ex_pkg::branch_result_t branch
);
    import ex_pkg::*;

    // Nothing valid while in reset
    assert property (@(posedge clock) !arst_n |->
            !alu_cdb.valid && !store_cdb.valid && !lb_request.valid && !branch.take_branch)
        else $error("valid output during reset");

    assert property (@(posedge clock) disable iff (!arst_n) squash |=>
            !alu_cdb.valid && !store_cdb.valid && !lb_request.valid && !branch.take_branch)
        else $error("valid output after squash");

    // One memory entry per cycle is either a load or a store
    assert property (@(posedge clock) disable iff (!arst_n)
            !(store_cdb.valid && lb_request.valid))
        else $error("store and load valid together");

    assert property (@(posedge clock) disable iff (!arst_n)
            !branch.take_branch |-> branch.target_pc == '0)
        else $error("target_pc nonzero on untaken branch");

endmodule

bind execute_stage execute_stage_props props0 (.*);

// File: verification/execute_stage_tb.sv
module execute_stage_tb;
    import ex_pkg::*;

    logic               clock;
    logic               arst_n;
    logic               squash;
    instr_ready_entry_t alu_entry;
    instr_ready_entry_t mem_entry;
    ex_wr_packet_t      alu_cdb;
    ex_wr_packet_t      store_cdb;
    lb_packet_t         lb_request;
    branch_result_t     branch;

    logic [31:0] seed = 32'h3cfb9a08;
    int          errors = 0;
    int          cycles = 0;

    execute_stage dut0 (
        .clock      (clock),
        .arst_n     (arst_n),
        .squash     (squash),
        .alu_entry  (alu_entry),
        .mem_entry  (mem_entry),
        .alu_cdb    (alu_cdb),
        .store_cdb  (store_cdb),
        .lb_request (lb_request),
        .branch     (branch)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // Tests take about 740 cycles
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == 2000) begin
            $display("ERROR: timeout, tests still running after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // kind is {rd_mem, wr_mem, cond_branch, uncond_branch}
    function automatic instr_ready_entry_t make_entry(input logic [31:0] inst,
            input opa_select_e sa, input opb_select_e sb, input alu_func_e f,
            input logic [3:0] kind, input logic [31:0] rs1, input logic [31:0] rs2);
        instr_ready_entry_t e;
        logic [31:0]        r;
        e = '0;
        r = next_rand();
        e.ready = 1'b1;
        e.instr.inst = inst;
        e.instr.pc = {r[31:2], 2'b00};
        e.instr.npc = {r[31:2], 2'b00} + 32'd4;
        e.instr.opa_select = sa;
        e.instr.opb_select = sb;
        e.instr.alu_func = f;
        {e.instr.rd_mem, e.instr.wr_mem, e.instr.cond_branch, e.instr.uncond_branch} = kind;
        e.rs1_value = rs1;
        e.rs2_value = rs2;
        e.rd_tag = r[6:2];
        return e;
    endfunction

    function automatic logic [31:0] alu_model(input logic [31:0] a, input logic [31:0] b,
            input alu_func_e f);
        logic [63:0] p;
        logic [4:0]  sh;
        sh = b[4:0];
        case (f)
            alu_add:    return a + b;
            alu_sub:    return a + ~b + 32'd1;
            alu_slt:    return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            alu_sltu:   return {31'd0, a < b};
            alu_and:    return a & b;
            alu_or:     return a | b;
            alu_xor:    return a ^ b;
            alu_sll:    return a << sh;
            alu_srl:    return a >> sh;
            alu_sra:    return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
            alu_mul: begin
                p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                return p[31:0];
            end
            alu_mulh: begin
                p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                return p[63:32];
            end
            alu_mulhsu: begin
                p = {{32{a[31]}}, a} * {32'd0, b};
                return p[63:32];
            end
            alu_mulhu: begin
                p = {32'd0, a} * {32'd0, b};
                return p[63:32];
            end
            default:    return 32'hfacebeec;
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input instr_ready_entry_t e);
        logic [31:0] a;
        logic [31:0] b;
        case (e.instr.opa_select)
            opa_is_rs1: a = e.rs1_value;
            opa_is_npc: a = e.instr.npc;
            opa_is_pc:  a = e.instr.pc;
            default:    a = 32'd0;
        endcase
        case (e.instr.opb_select)
            opb_is_rs2:   b = e.rs2_value;
            opb_is_i_imm: b = i_imm(e.instr.inst);
            opb_is_s_imm: b = s_imm(e.instr.inst);
            opb_is_b_imm: b = b_imm(e.instr.inst);
            opb_is_u_imm: b = u_imm(e.instr.inst);
            default:      b = j_imm(e.instr.inst);
        endcase
        return alu_model(a, b, e.instr.alu_func);
    endfunction

    function automatic logic branch_cond_model(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        logic slt;
        slt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return slt;
            3'b101:  return !slt;
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic predict(input instr_ready_entry_t a, input instr_ready_entry_t m,
            input logic sq, output ex_wr_packet_t ea, output ex_wr_packet_t es,
            output lb_packet_t el, output branch_result_t eb);
        logic [31:0] res;
        logic        take;
        ea = '0;
        es = '0;
        el = '0;
        eb = '0;
        res = expected_result(a);
        take = a.instr.uncond_branch
            | (a.instr.cond_branch
            & branch_cond_model(funct3(a.instr.inst), a.rs1_value, a.rs2_value));
        if (a.ready && !sq) begin
            ea = '{1'b1, 32'd0, a.rd_tag, a.instr.npc, a.instr.inst};
            if (take) begin
                eb = '{1'b1, res};
                ea.value = a.instr.npc;
            end else if (!a.instr.cond_branch && !a.instr.uncond_branch) begin
                ea.value = res;
            end
        end
        res = expected_result(m);
        if (m.ready && !sq) begin
            if (m.instr.rd_mem)
                el = '{1'b1, res, m.rd_tag, funct3(m.instr.inst), m.instr.npc, m.instr.inst};
            else
                es = '{1'b1, res, m.rd_tag, m.instr.npc, m.instr.inst};
        end
    endtask

    // Payload only matters while valid
    task automatic compare_wr(input ex_wr_packet_t got, input ex_wr_packet_t exp,
            input string msg);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_lb(input lb_packet_t got, input lb_packet_t exp, input string msg);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_branch(input branch_result_t got, input branch_result_t exp,
            input string msg);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_all(input ex_wr_packet_t ea, input ex_wr_packet_t es,
            input lb_packet_t el, input branch_result_t eb, input string msg);
        compare_wr(alu_cdb, ea, {msg, " alu_cdb"});
        compare_wr(store_cdb, es, {msg, " store_cdb"});
        compare_lb(lb_request, el, {msg, " lb_request"});
        compare_branch(branch, eb, {msg, " branch"});
    endtask

    // One entry per port, result checked one cycle later
    task automatic run_step(input instr_ready_entry_t a, input instr_ready_entry_t m,
            input logic sq, input string msg);
        ex_wr_packet_t  ea;
        ex_wr_packet_t  es;
        lb_packet_t     el;
        branch_result_t eb;
        predict(a, m, sq, ea, es, el, eb);
        @(posedge clock);
        alu_entry <= a;
        mem_entry <= m;
        squash    <= sq;
        @(posedge clock);
        alu_entry <= '0;
        mem_entry <= '0;
        squash    <= 1'b0;
        @(negedge clock);
        check_all(ea, es, el, eb, msg);
    endtask

    task automatic exercise_integer_ops();
        for (int f = 0; f < 10; f++)
            for (int i = 0; i < 20; i++)
                run_step(make_entry(next_rand(), opa_is_rs1, opb_is_rs2, alu_func_e'(f),
                    4'b0000, next_rand(), next_rand()), '0, 1'b0, "integer");
    endtask

    task automatic sweep_multiplies();
        logic [31:0] corner[4] = '{32'h80000000, 32'hffffffff, 32'h7fffffff, 32'd1};
        for (int f = 10; f < 14; f++) begin
            for (int i = 0; i < 10; i++)
                run_step(make_entry(next_rand(), opa_is_rs1, opb_is_rs2, alu_func_e'(f),
                    4'b0000, next_rand(), next_rand()), '0, 1'b0, "multiply");
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    run_step(make_entry(next_rand(), opa_is_rs1, opb_is_rs2, alu_func_e'(f),
                        4'b0000, corner[i], corner[j]), '0, 1'b0, "multiply corner");
        end
    endtask

    task automatic cover_operand_selects();
        logic [31:0] inst;
        for (int s = 0; s < 2; s++) begin
            inst = s ? (next_rand() | 32'h80000000) : (next_rand() & 32'h7fffffff);
            for (int a = 1; a < 4; a++)
                run_step(make_entry(inst, opa_select_e'(a), opb_is_rs2, alu_add, 4'b0000,
                    next_rand(), next_rand()), '0, 1'b0, "operand a");
            for (int b = 1; b < 6; b++)
                run_step(make_entry(inst, opa_is_rs1, opb_select_e'(b), alu_add, 4'b0000,
                    next_rand(), next_rand()), '0, 1'b0, "operand b");
        end
    endtask

    task automatic resolve_branches();
        logic [2:0]  conds[6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [31:0] lhs[5] = '{32'd5, 32'd3, 32'd9, 32'hfffffff0, 32'd16};
        logic [31:0] rhs[5] = '{32'd5, 32'd9, 32'd3, 32'd16, 32'hfffffff0};
        logic [31:0] inst;
        for (int c = 0; c < 6; c++)
            for (int p = 0; p < 5; p++) begin
                inst = next_rand();
                inst[14:12] = conds[c];
                run_step(make_entry(inst, opa_is_pc, opb_is_b_imm, alu_add, 4'b0010,
                    lhs[p], rhs[p]), '0, 1'b0, "branch");
            end
        run_step(make_entry(next_rand(), opa_is_pc, opb_is_j_imm, alu_add, 4'b0001,
            next_rand(), next_rand()), '0, 1'b0, "jal");
        run_step(make_entry(next_rand(), opa_is_rs1, opb_is_i_imm, alu_add, 4'b0001,
            next_rand(), next_rand()), '0, 1'b0, "jalr");
    endtask

    task automatic issue_loads_stores();
        logic [2:0]  sizes[5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [31:0] inst;
        for (int i = 0; i < 5; i++) begin
            inst = next_rand();
            inst[14:12] = sizes[i];
            run_step('0, make_entry(inst, opa_is_rs1, opb_is_i_imm, alu_add, 4'b1000,
                next_rand(), next_rand()), 1'b0, "load");
        end
        for (int i = 0; i < 3; i++) begin
            inst = next_rand();
            inst[14:12] = sizes[i];
            run_step('0, make_entry(inst, opa_is_rs1, opb_is_s_imm, alu_add, 4'b0100,
                next_rand(), next_rand()), 1'b0, "store");
        end
    endtask

    task automatic flush_and_pipeline();
        instr_ready_entry_t a1;
        instr_ready_entry_t a2;
        instr_ready_entry_t m1;
        instr_ready_entry_t m2;
        ex_wr_packet_t      ea1;
        ex_wr_packet_t      es1;
        lb_packet_t         el1;
        branch_result_t     eb1;
        ex_wr_packet_t      ea2;
        ex_wr_packet_t      es2;
        lb_packet_t         el2;
        branch_result_t     eb2;
        a1 = make_entry(next_rand(), opa_is_pc, opb_is_j_imm, alu_add, 4'b0001, 32'd1, 32'd2);
        m1 = make_entry(next_rand(), opa_is_rs1, opb_is_i_imm, alu_add, 4'b1000, 32'd7, 32'd0);
        run_step(a1, m1, 1'b1, "squash");
        a1.ready = 1'b0;
        m1.ready = 1'b0;
        run_step(a1, m1, 1'b0, "not ready");
        // Back-to-back issue on consecutive cycles
        a1 = make_entry(next_rand(), opa_is_rs1, opb_is_rs2, alu_xor, 4'b0000,
            next_rand(), next_rand());
        a2 = make_entry(next_rand(), opa_is_rs1, opb_is_rs2, alu_sub, 4'b0000,
            next_rand(), next_rand());
        m1 = make_entry(next_rand(), opa_is_rs1, opb_is_s_imm, alu_add, 4'b0100,
            next_rand(), next_rand());
        m2 = make_entry(next_rand(), opa_is_rs1, opb_is_i_imm, alu_add, 4'b1000,
            next_rand(), next_rand());
        predict(a1, m1, 1'b0, ea1, es1, el1, eb1);
        predict(a2, m2, 1'b0, ea2, es2, el2, eb2);
        @(posedge clock);
        alu_entry <= a1;
        mem_entry <= m1;
        @(posedge clock);
        alu_entry <= a2;
        mem_entry <= m2;
        @(negedge clock);
        check_all(ea1, es1, el1, eb1, "back-to-back first");
        @(posedge clock);
        alu_entry <= '0;
        mem_entry <= '0;
        @(negedge clock);
        check_all(ea2, es2, el2, eb2, "back-to-back second");
        // Reset arriving while a jal and a store are captured
        a1 = make_entry(next_rand(), opa_is_pc, opb_is_j_imm, alu_add, 4'b0001,
            next_rand(), next_rand());
        m1 = make_entry(next_rand(), opa_is_rs1, opb_is_s_imm, alu_add, 4'b0100,
            next_rand(), next_rand());
        @(posedge clock);
        alu_entry <= a1;
        mem_entry <= m1;
        @(posedge clock);
        arst_n <= 1'b0;
        @(negedge clock);
        check_all('0, '0, '0, '0, "reset in flight");
        @(posedge clock);
        arst_n    <= 1'b1;
        alu_entry <= '0;
        mem_entry <= '0;
    endtask

    initial begin
        arst_n    = 1'b0;
        squash    = 1'b0;
        alu_entry = '0;
        mem_entry = '0;
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        check_all('0, '0, '0, '0, "after reset");
        exercise_integer_ops();
        sweep_multiplies();
        cover_operand_selects();
        resolve_branches();
        issue_loads_stores();
        flush_and_pipeline();
        $display("Tests done, %0d errors", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb.f
hw/ex_pkg.sv
hw/alu.sv
hw/brcond.sv
hw/operand_select.sv
hw/alu_execution_unit.sv
hw/address_calculation_unit.sv
hw/ex_stage_regs.sv
hw/execute_stage.sv
verification/execute_stage_props.sv
verification/execute_stage_tb.sv

// File: Makefile
TOP = execute_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f tb.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
